//--- build.f
+incdir+testbench
design/cart_pkg.sv
design/mem_pkg.sv
design/header_capture.sv
design/bank_regs.sv
design/rom_mapper.sv
design/cram_port.sv
design/cart_mapper_top.sv
testbench/tb_cart_mapper.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the cartridge mapper testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
	--top-module tb_cart_mapper \
	-f build.f \
	-Mdir obj_dir -o sim_cart

./obj_dir/sim_cart | tee sim.log

if grep -q "sim failed" sim.log; then
	echo "simulation reported a failure, see sim.log"
	exit 1
fi
echo "simulation finished without failures"

//--- testbench/cart_tests.svh
/* directed tests and bus helpers for the testbench module that includes them
   every task starts and ends 1 ns after a rising clk_sys */

task automatic next_cycle();
	@(posedge clk_sys);
	#1;
endtask

task automatic send_beat(input logic [24:0] addr, input logic [15:0] data);
	load_beat.addr = addr;
	load_beat.data = data;
	load_wr        = 1'b1;
	next_cycle();
	load_wr = 1'b0;
endtask

// header bytes sit high in 142h and 146h and the sizes share 148h
function automatic logic [15:0] header_word(input logic [24:0] addr, input logic [15:0] w);
	case (addr)
		25'h142: return {hdr_cgb, w[7:0]};
		25'h146: return {hdr_type, w[7:0]};
		25'h148: return {hdr_ram, hdr_rom};
		default: return w;
	endcase
endfunction

function automatic logic [7:0] image_byte(input logic [22:0] img_addr);
	logic [15:0] w;
	w = rom_model[img_addr[16:1]];
	return img_addr[0] ? w[15:8] : w[7:0]; // little endian words
endfunction

function automatic logic [22:0] bank_addr(input logic [8:0] bank, input logic [13:0] off);
	return {bank, off}; // 16 KB banks
endfunction

task automatic load_image(input logic [7:0] cgb, input logic [7:0] kind,
		input logic [7:0] rom_code, input logic [7:0] ram_code);
	int i;
	hdr_cgb     = cgb;
	hdr_type    = kind;
	hdr_rom     = rom_code;
	hdr_ram     = ram_code;
	load_active = 1'b1;
	for (i = 0; i < rom_words; i++)
		send_beat(25'(i * 2), header_word(25'(i * 2), lfsr_word()));
	load_active = 1'b0;
	next_cycle();
endtask

// rewrite only the three header words and keep the rest of the image
task automatic load_header(input logic [7:0] cgb, input logic [7:0] kind,
		input logic [7:0] rom_code, input logic [7:0] ram_code);
	hdr_cgb     = cgb;
	hdr_type    = kind;
	hdr_rom     = rom_code;
	hdr_ram     = ram_code;
	load_active = 1'b1;
	send_beat(25'h142, header_word(25'h142, rom_model[16'h00a1]));
	send_beat(25'h146, header_word(25'h146, rom_model[16'h00a3]));
	send_beat(25'h148, header_word(25'h148, rom_model[16'h00a4]));
	load_active = 1'b0;
	next_cycle();
endtask

task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
	cpu_req.addr  = addr;
	cpu_req.wdata = data;
	cpu_req.rd    = 1'b0;
	cpu_req.wr    = 1'b1;
	next_cycle();
	cpu_req.wr = 1'b0;
endtask

task automatic issue_read(input logic [15:0] addr, input logic [7:0] exp);
	due_q.push_back(cyc + 2); // request sampled next edge and data two edges on
	data_q.push_back(exp);
	cpu_req.addr  = addr;
	cpu_req.wdata = 8'h00;
	cpu_req.rd    = 1'b1;
	cpu_req.wr    = 1'b0;
	next_cycle();
	cpu_req.rd = 1'b0;
endtask

task automatic rom_read(input logic [15:0] addr, input logic [22:0] img_addr);
	word_q.push_back(img_addr[22:1]);
	issue_read(addr, image_byte(img_addr));
endtask

task automatic wait_returns();
	int n;
	n = 0;
	while ((due_q.size() != 0 || word_q.size() != 0) && n < 6) begin
		next_cycle();
		n++;
	end
	if (due_q.size() != 0 || word_q.size() != 0) begin
		errors++;
		$display("reads still outstanding %0d cycles after the last request", n);
		due_q.delete();
		data_q.delete();
		word_q.delete();
	end
endtask

// ----------------------------------------
task automatic header_and_blank_reads();
	word_q.push_back(22'h000000); // nothing loaded so the rom reads 00
	issue_read(16'h0000, 8'h00);
	word_q.push_back(22'h002000); // no mapper yet so bank 1
	issue_read(16'h4000, 8'h00);
	wait_returns();
	load_image(8'hc0, 8'h01, 8'h02, 8'h00); // mbc1 with 128 KB
	checks++;
	if (cart_cgb !== 1'b1) begin
		errors++;
		$display("FAIL cart_cgb got %h exp %h", cart_cgb, 1'b1);
	end
	rom_read(16'h4abc, bank_addr(9'd1, 14'h0abc)); // bank 1 after load
	wait_returns();
endtask

task automatic plain_rom_reads();
	load_header(8'h00, 8'h00, 8'h00, 8'h00);
	checks++;
	if (cart_cgb !== 1'b0) begin
		errors++;
		$display("FAIL cart_cgb got %h exp %h", cart_cgb, 1'b0);
	end
	rom_read(16'h0000, 23'h000000);
	wait_returns();
	rom_read(16'h4000, 23'h004000);
	rom_read(16'h0001, 23'h000001); // back to back on the odd lane
	wait_returns();
	cpu_write(16'h2000, 8'h03);     // no registers so still bank 1
	rom_read(16'h7fff, 23'h007fff);
	issue_read(16'hc000, 8'hff);    // neither rom nor ram
	wait_returns();
endtask

task automatic mbc1_bank_select();
	load_header(8'h80, 8'h01, 8'h02, 8'h00); // 8 banks under mask 7
	cpu_write(16'h2000, 8'h00);              // 0 becomes 1
	rom_read(16'h4123, bank_addr(9'd1, 14'h0123));
	cpu_write(16'h2000, 8'h0d);              // 13 wraps to 5
	rom_read(16'h5555, bank_addr(9'd5, 14'h1555));
	rom_read(16'h0042, 23'h000042);          // lower window fixed
	wait_returns();
	load_header(8'h80, 8'h01, 8'h05, 8'h00); // 64 banks under mask 63
	cpu_write(16'h2000, 8'h02);
	cpu_write(16'h4000, 8'h01);              // upper rom bits in mode 0
	rom_read(16'h4010, bank_addr(9'h022, 14'h0010));
	cpu_write(16'h6000, 8'h01);              // mode 1 drops them
	rom_read(16'h4011, bank_addr(9'h002, 14'h0011));
	wait_returns();
endtask

task automatic mbc5_wide_bank();
	load_header(8'hc0, 8'h19, 8'h08, 8'h03); // 512 banks
	cpu_write(16'h2000, 8'ha6);
	cpu_write(16'h3000, 8'h01);              // bit 8
	rom_read(16'h4321, bank_addr(9'h1a6, 14'h0321));
	cpu_write(16'h2000, 8'h00);
	cpu_write(16'h3000, 8'h00);              // bank 0 is legal here
	rom_read(16'h4322, bank_addr(9'h000, 14'h0322));
	wait_returns();
	load_header(8'hc0, 8'h19, 8'h04, 8'h03); // 32 banks
	cpu_write(16'h2000, 8'ha6);
	cpu_write(16'h3000, 8'h01);
	rom_read(16'h7ffe, bank_addr(9'h006, 14'h3ffe)); // 1a6 masked to 6
	wait_returns();
endtask

task automatic cart_ram_access();
	load_header(8'h00, 8'h19, 8'h04, 8'h03); // 32 KB ram in 4 banks
	issue_read(16'ha000, 8'hff);             // locked after load
	cpu_write(16'h0000, 8'h0a);
	cpu_write(16'h4000, 8'h02);
	cpu_write(16'ha123, 8'h5c);
	issue_read(16'ha123, 8'h5c);
	cpu_write(16'h4000, 8'h01);
	cpu_write(16'ha123, 8'h3b);              // same offset in bank 1
	cpu_write(16'h4000, 8'h05);              // 5 aliases to 1
	issue_read(16'ha123, 8'h3b);
	cpu_write(16'h4000, 8'h02);
	issue_read(16'ha123, 8'h5c);             // bank 2 kept its own byte
	cpu_write(16'h1fff, 8'h00);              // lock
	issue_read(16'ha123, 8'hff);
	cpu_write(16'ha123, 8'h77);              // dropped while locked
	cpu_write(16'h0000, 8'h0a);
	issue_read(16'ha123, 8'h5c);
	wait_returns();
endtask

task automatic mapper_ram_rules();
	load_header(8'h00, 8'h05, 8'h01, 8'h00); // mbc2
	issue_read(16'ha010, 8'hff);             // the load locked the ram again
	cpu_write(16'h0000, 8'h0a);
	cpu_write(16'ha010, 8'hc7);
	issue_read(16'ha010, 8'hf7);             // only the low nibble is kept
	wait_returns();
	load_header(8'h00, 8'h10, 8'h01, 8'h03); // mbc3 with 32 KB ram
	cpu_write(16'h0000, 8'h0a);
	cpu_write(16'h4000, 8'h02);
	cpu_write(16'ha020, 8'h99);
	issue_read(16'ha020, 8'h99);
	cpu_write(16'h4000, 8'h08);              // rtc register select
	issue_read(16'ha020, 8'h00);
	cpu_write(16'h4000, 8'h02);
	issue_read(16'ha020, 8'h99);
	wait_returns();
endtask

//--- testbench/tb_cart_mapper.sv
/* testbench for the cartridge mapper; the rom model holds 64K words, so rom_addr is
   checked in full while read data comes from the low 16 word-address bits */
`timescale 1ns/1ps
`default_nettype none

module tb_cart_mapper;

	localparam int rom_words    = 65536;
	localparam int image_cycles = rom_words + 4; // one beat per cycle plus framing
	localparam int test_cycles  = 6 * 100;       // six tests, each well under 100 cycles
	localparam int cycle_limit  = 3 + image_cycles + test_cycles;

	logic                 clk_sys;
	logic                 reset;
	logic                 load_active;
	logic                 load_wr;
	mem_pkg::load_beat_t  load_beat;
	mem_pkg::cpu_req_t    cpu_req;
	logic                 rom_rd;
	logic [21:0]          rom_addr;
	logic [15:0]          rom_data = 16'h0000;
	logic                 rd_valid;
	logic [7:0]           rdata;
	logic                 cart_cgb;

	logic [15:0] rom_model [rom_words]; // external rom, filled by the load stream
	logic [31:0] lfsr_state;
	logic        ans_rd;
	logic [21:0] ans_addr;
	int          cyc = 0;
	int          checks;
	int          errors;

	// header bytes patched into the image
	logic [7:0] hdr_cgb;
	logic [7:0] hdr_type;
	logic [7:0] hdr_rom;
	logic [7:0] hdr_ram;

	// expected returns, oldest first
	int          due_q[$];  // cycle in which rd_valid is due
	logic [7:0]  data_q[$];
	logic [21:0] word_q[$]; // rom word addresses, rom reads only
	int          exp_due;
	logic [7:0]  exp_data;
	logic [21:0] exp_word;

	cart_mapper_top #(
		.ROM_WORD_W  (22),
		.CRAM_ADDR_W (17)
	) u_cart_mapper_top (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.load_active (load_active),
		.load_wr     (load_wr),
		.load_beat   (load_beat),
		.cpu_req     (cpu_req),
		.rom_rd      (rom_rd),
		.rom_addr    (rom_addr),
		.rom_data    (rom_data),
		.rd_valid    (rd_valid),
		.rdata       (rdata),
		.cart_cgb    (cart_cgb)
	);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys; // 8 ns period
	end

	always @(posedge clk_sys) begin
		cyc = cyc + 1;
		if (cyc > cycle_limit) begin
			$display("timeout, cycle limit %0d reached before the tests finished", cycle_limit);
			$display("sim failed");
			$finish;
		end
	end

	// ----------------------------------------
	// rom model, answers rom_rd one cycle later
	always @(posedge clk_sys) begin
		if (load_active && load_wr)
			rom_model[load_beat.addr[16:1]] <= load_beat.data; // byte address, word beats
		ans_rd   = rom_rd;
		ans_addr = rom_addr;
		#1;
		if (ans_rd)
			rom_data = rom_model[ans_addr[15:0]]; // upper bits alias
	end

	// ----------------------------------------
	// return checker, mid-cycle when outputs are settled
	always @(negedge clk_sys) begin
		if (!reset) begin
			if (rom_rd) begin
				if (word_q.size() == 0) begin
					errors++;
					$display("rom read issued where none was expected, word %h", rom_addr);
				end else begin
					exp_word = word_q.pop_front();
					checks++;
					if (rom_addr !== exp_word) begin
						errors++;
						$display("FAIL rom_addr got %h exp %h", rom_addr, exp_word);
					end
				end
			end
			if (rd_valid) begin
				if (due_q.size() == 0) begin
					errors++;
					$display("rd_valid pulsed with no read outstanding");
				end else begin
					exp_due  = due_q.pop_front();
					exp_data = data_q.pop_front();
					checks++;
					if (cyc != exp_due) begin
						errors++;
						$display("FAIL rd_valid cycle got %h exp %h", cyc, exp_due);
					end
					if (rdata !== exp_data) begin
						errors++;
						$display("FAIL rdata got %h exp %h", rdata, exp_data);
					end
				end
			end else if (due_q.size() != 0 && due_q[0] <= cyc) begin
				errors++;
				$display("read due in cycle %0d never returned", due_q[0]);
				void'(due_q.pop_front());
				void'(data_q.pop_front());
			end
		end
	end

	// fibonacci lfsr, taps 32 22 2 1, one step per bit
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic logic [15:0] lfsr_word();
		logic [15:0] w;
		int          k;
		w = '0;
		for (k = 0; k < 16; k++)
			w = {w[14:0], lfsr_bit()};
		return w;
	endfunction

	`include "cart_tests.svh"

	initial begin
		reset       = 1'b1;
		load_active = 1'b0;
		load_wr     = 1'b0;
		load_beat   = '0;
		cpu_req     = '0;
		lfsr_state  = 32'hf664_a441;
		checks      = 0;
		errors      = 0;
		repeat (3) @(posedge clk_sys);
		#1;
		reset = 1'b0;

		header_and_blank_reads();
		plain_rom_reads();
		mbc1_bank_select();
		mbc5_wide_bank();
		cart_ram_access();
		mapper_ram_rules();

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- design/cart_mapper_top.sv
/* cartridge mapper top; one cpu request per clk_sys, every read returns 2 cycles later
   rom lives outside and must answer rom_rd with rom_data on the next cycle */
`timescale 1ns/1ps
`default_nettype none

module cart_mapper_top #(
	parameter int ROM_WORD_W  = 22, // 8 MB of rom words
	parameter int CRAM_ADDR_W = 17  // 128 KB cart ram
) (
	input  wire                      clk_sys,
	input  wire                      reset,
	input  wire                      load_active,
	input  wire                      load_wr,
	input  wire mem_pkg::load_beat_t load_beat,
	input  wire mem_pkg::cpu_req_t   cpu_req,
	output logic                     rom_rd,
	output logic [ROM_WORD_W-1:0]    rom_addr,
	input  wire  [15:0]              rom_data,
	output logic                     rd_valid,
	output logic [7:0]               rdata,
	output logic                     cart_cgb
);

	mem_pkg::cart_cfg_t   cart_cfg;
	mem_pkg::bank_state_t bank;
	logic                 cart_ready;
	logic [7:0]           rom_byte;
	logic                 rom_valid;
	logic [7:0]           cram_byte;
	logic                 cram_valid;
	logic                 other_valid;

	header_capture u_header_capture (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.load_active (load_active),
		.load_wr     (load_wr),
		.load_beat   (load_beat),
		.cart_cfg    (cart_cfg),
		.cart_ready  (cart_ready)
	);

	bank_regs u_bank_regs (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.load_active (load_active),
		.cpu_req     (cpu_req),
		.cart_cfg    (cart_cfg),
		.bank        (bank)
	);

	rom_mapper #(.ROM_WORD_W(ROM_WORD_W)) u_rom_mapper (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cpu_req    (cpu_req),
		.cart_cfg   (cart_cfg),
		.bank       (bank),
		.cart_ready (cart_ready),
		.rom_rd     (rom_rd),
		.rom_addr   (rom_addr),
		.rom_data   (rom_data),
		.rom_byte   (rom_byte),
		.rom_valid  (rom_valid)
	);

	cram_port #(.CRAM_ADDR_W(CRAM_ADDR_W)) u_cram_port (
		.clk_sys     (clk_sys),
		.cpu_req     (cpu_req),
		.cart_cfg    (cart_cfg),
		.bank        (bank),
		.cram_byte   (cram_byte),
		.cram_valid  (cram_valid),
		.other_valid (other_valid)
	);

	// both sides drive 00 when idle
	assign rd_valid = rom_valid || cram_valid || other_valid;
	assign rdata    = rom_byte | cram_byte;
	assign cart_cgb = cart_cfg.cgb_game;

	a_rd_latency: assert property (@(posedge clk_sys) disable iff (reset)
		cpu_req.rd |-> ##2 rd_valid);
	a_one_source: assert property (@(posedge clk_sys) disable iff (reset)
		$onehot0({rom_valid, cram_valid, other_valid}));

endmodule

`default_nettype wire

//--- design/cram_port.sv
/* on-chip cartridge ram at a000-bfff for CRAM_ADDR_W from 13 to 17
   also answers reads of 8000-9fff and c000-ffff with ff so every read returns */
`timescale 1ns/1ps
`default_nettype none

module cram_port #(
	parameter int CRAM_ADDR_W = 17
) (
	input  wire                       clk_sys,
	input  wire mem_pkg::cpu_req_t    cpu_req,
	input  wire mem_pkg::cart_cfg_t   cart_cfg,
	input  wire mem_pkg::bank_state_t bank,
	output logic [7:0]                cram_byte,
	output logic                      cram_valid,
	output logic                      other_valid
);

	localparam int cram_depth = 1 << CRAM_ADDR_W;

	logic [7:0]             mem [cram_depth];
	logic [3:0]             bank_field;
	logic [16:0]            ram_full;
	logic [CRAM_ADDR_W-1:0] ram_addr;
	logic                   is_cram;
	logic                   is_other;

	// array read stage
	logic [7:0] q;
	logic       rd_a;
	logic       other_a;
	logic       en_a;
	logic       nib_a;   // mbc2 nibble ram a000-a1ff
	logic       rtc_a;
	logic [7:0] value;

	assign is_cram  = (cpu_req.addr[15:13] == 3'b101);
	assign is_other = cpu_req.addr[15] && !is_cram; // 8000-9fff and c000-ffff

	always_comb begin
		case (cart_cfg.kind)
			// mode 0 unbanked
			cart_pkg::kind_mbc1: bank_field = bank.mbc1_mode ? bank.ram_bank : 4'd0;
			cart_pkg::kind_mbc3,
			cart_pkg::kind_mbc5: bank_field = bank.ram_bank;
			default:             bank_field = 4'd0; // mbc2 and plain carts
		endcase
	end

	assign ram_full = {bank_field & cart_cfg.ram_mask, cpu_req.addr[12:0]};
	assign ram_addr = CRAM_ADDR_W'(ram_full); // small arrays alias the upper banks

	always_ff @(posedge clk_sys) begin
		if (cpu_req.wr && is_cram && bank.ram_en)
			mem[ram_addr] <= cpu_req.wdata;
		q <= mem[ram_addr];
	end

	// rules sampled with the request
	always_ff @(posedge clk_sys) begin
		rd_a    <= cpu_req.rd && is_cram;
		other_a <= cpu_req.rd && is_other;
		en_a    <= bank.ram_en;
		nib_a   <= (cart_cfg.kind == cart_pkg::kind_mbc2) && (cpu_req.addr[15:9] == 7'b1010000);
		rtc_a   <= bank.rtc_mode;
	end

	always_comb begin
		if (!en_a)
			value = 8'hff; // locked ram floats high
		else if (nib_a)
			value = {4'hf, q[3:0]};
		else if (rtc_a)
			value = 8'h00; // no clock behind it
		else
			value = q;
	end

	always_ff @(posedge clk_sys) begin
		cram_valid  <= rd_a;
		other_valid <= other_a;
		if (rd_a)
			cram_byte <= value;
		else if (other_a)
			cram_byte <= 8'hff; // open bus
		else
			cram_byte <= 8'h00; // idle so the top can OR
	end

endmodule

`default_nettype wire

//--- design/rom_mapper.sv
/* rom window 0000-7fff; external rom answers rom_rd with a word one cycle later
   bytes read as 00 until the first image beat has arrived */
`timescale 1ns/1ps
`default_nettype none

module rom_mapper #(
	parameter int ROM_WORD_W = 22
) (
	input  wire                       clk_sys,
	input  wire                       reset,
	input  wire mem_pkg::cpu_req_t    cpu_req,
	input  wire mem_pkg::cart_cfg_t   cart_cfg,
	input  wire mem_pkg::bank_state_t bank,
	input  wire                       cart_ready,
	output logic                      rom_rd,
	output logic [ROM_WORD_W-1:0]     rom_addr,
	input  wire  [15:0]               rom_data,
	output logic [7:0]                rom_byte,
	output logic                      rom_valid
);

	logic [8:0]  bank_sel;  // 16k bank number
	logic [22:0] byte_addr; // up to 8 MB
	logic        odd_a;     // byte lane beside rom_rd
	logic        odd_b;     // byte lane beside rom_data
	logic [7:0]  lane;

	always_comb begin
		bank_sel = 9'd0; // 0000-3fff always bank 0
		if (cpu_req.addr[14]) begin
			case (cart_cfg.kind)
				cart_pkg::kind_mbc1: begin
					// mode 0 lets the ram bank bits drive rom a19-a20
					bank_sel = {2'b00, (bank.mbc1_mode ? 2'b00 : bank.ram_bank[1:0]),
						bank.rom_bank[4:0]} & cart_cfg.rom_mask;
				end
				cart_pkg::kind_mbc2,
				cart_pkg::kind_mbc3: bank_sel = {2'b00, bank.rom_bank[6:0]} & cart_cfg.rom_mask;
				cart_pkg::kind_mbc5: bank_sel = bank.rom_bank & cart_cfg.rom_mask;
				default:             bank_sel = 9'd1; // plain 32k
			endcase
		end
	end

	assign byte_addr = {bank_sel, cpu_req.addr[13:0]};

	// ----------------------------------------
	// request stage, then return stage
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_rd    <= 1'b0;
			rom_valid <= 1'b0;
		end else begin
			rom_rd    <= cpu_req.rd && !cpu_req.addr[15];
			rom_valid <= rom_rd; // rom_data lands now
		end
	end

	always_ff @(posedge clk_sys) begin
		rom_addr <= ROM_WORD_W'(byte_addr[22:1]); // word address
		odd_a    <= byte_addr[0];
		odd_b    <= odd_a;
	end

	assign lane     = odd_b ? rom_data[15:8] : rom_data[7:0]; // little endian words
	assign rom_byte = (rom_valid && cart_ready) ? lane : 8'h00; // zero when idle, top ORs

	a_rom_ret: assert property (@(posedge clk_sys) disable iff (reset)
		rom_valid |-> $past(rom_rd));

endmodule

`default_nettype wire

//--- design/bank_regs.sv
/* mapper registers written by the cpu at 0000-7fff
   held at power-on values while an image loads; rtc registers are not kept */
`timescale 1ns/1ps
`default_nettype none

module bank_regs (
	input  wire                      clk_sys,
	input  wire                      reset,
	input  wire                      load_active,
	input  wire mem_pkg::cpu_req_t   cpu_req,
	input  wire mem_pkg::cart_cfg_t  cart_cfg,
	output mem_pkg::bank_state_t     bank
);

	// rom bank 1 mapped at 4000, everything else off
	localparam mem_pkg::bank_state_t bank_init = '{
		rom_bank:  9'd1,
		ram_bank:  4'd0,
		mbc1_mode: 1'b0,
		rtc_mode:  1'b0,
		ram_en:    1'b0
	};

	cart_pkg::region_e      region;
	cart_pkg::ram_bank_wr_u bank_wr;
	logic                   reg_wr; // write into the rom window

	assign region  = cart_pkg::region_e'(cpu_req.addr[15:13]);
	assign bank_wr = cpu_req.wdata;
	assign reg_wr  = cpu_req.wr && !cpu_req.addr[15];

	always_ff @(posedge clk_sys) begin
		if (reset || load_active) begin
			bank <= bank_init;
		end else if (reg_wr) begin
			case (region)
				cart_pkg::region_ram_en: begin
					bank.ram_en <= (cpu_req.wdata[3:0] == cart_pkg::ram_en_key); // any other value locks
				end
				cart_pkg::region_rom_bank: begin
					if (cart_cfg.kind == cart_pkg::kind_mbc5) begin
						if (cpu_req.addr[12])
							bank.rom_bank[8] <= cpu_req.wdata[0]; // 3000-3fff, high bit
						else
							bank.rom_bank[7:0] <= cpu_req.wdata; // 2000-2fff, bank 0 allowed
					end else if (cpu_req.wdata[6:0] == 7'd0) begin
						bank.rom_bank <= 9'd1; // older mappers never map bank 0 up here
					end else begin
						bank.rom_bank <= {2'b00, cpu_req.wdata[6:0]};
					end
				end
				cart_pkg::region_ram_bank: begin
					if (cart_cfg.kind == cart_pkg::kind_mbc3) begin
						if (bank_wr.mbc3.rtc_sel) begin
							bank.rtc_mode <= 1'b1;
						end else begin
							bank.rtc_mode <= 1'b0;
							bank.ram_bank <= {2'b00, bank_wr.mbc3.bank};
						end
					end else if (cart_cfg.kind == cart_pkg::kind_mbc5) begin
						bank.ram_bank <= bank_wr.mbc5.bank;
					end else begin
						bank.ram_bank <= {2'b00, cpu_req.wdata[1:0]}; // mbc1 upper bits live here too
					end
				end
				cart_pkg::region_mode: begin
					if (cart_cfg.kind == cart_pkg::kind_mbc1)
						bank.mbc1_mode <= cpu_req.wdata[0];
				end
				default: ;
			endcase
		end
	end

	// the console bus never reads and writes in the same cycle
	a_rd_wr_excl: assert property (@(posedge clk_sys) disable iff (reset)
		!(cpu_req.rd && cpu_req.wr));

endmodule

`default_nettype wire

//--- design/header_capture.sv
/* snoops the header words while an image loads; fields hold until the next load
   cart_ready stays set once the first beat has been seen */
`timescale 1ns/1ps
`default_nettype none

module header_capture (
	input  wire                     clk_sys,
	input  wire                     reset,
	input  wire                     load_active,
	input  wire                     load_wr,
	input  wire mem_pkg::load_beat_t load_beat,
	output mem_pkg::cart_cfg_t      cart_cfg,
	output logic                    cart_ready
);

	logic [7:0] cgb_flag;
	logic [7:0] mbc_type;
	logic [7:0] rom_size;
	logic [7:0] ram_size;
	logic [9:0] rom_top; // 2^(n+1)-1, one bit wider than the mask

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cgb_flag   <= 8'h00;
			mbc_type   <= 8'h00;
			rom_size   <= 8'h00;
			ram_size   <= 8'h00;
			cart_ready <= 1'b0;
		end else if (load_active && load_wr) begin
			cart_ready <= 1'b1;
			case (load_beat.addr)
				cart_pkg::hdr_cgb_off:  cgb_flag <= load_beat.data[15:8];
				cart_pkg::hdr_type_off: mbc_type <= load_beat.data[15:8];
				cart_pkg::hdr_size_off: begin
					rom_size <= load_beat.data[7:0];  // 148h
					ram_size <= load_beat.data[15:8]; // 149h
				end
				default: ;
			endcase
		end
	end

	// decode, purely from the stored bytes
	always_comb begin
		if (mbc_type inside {[8'h01:8'h03]})
			cart_cfg.kind = cart_pkg::kind_mbc1;
		else if (mbc_type inside {[8'h05:8'h06]})
			cart_cfg.kind = cart_pkg::kind_mbc2;
		else if (mbc_type inside {[8'h0f:8'h13]})
			cart_cfg.kind = cart_pkg::kind_mbc3;
		else if (mbc_type inside {[8'h19:8'h1e]})
			cart_cfg.kind = cart_pkg::kind_mbc5;
		else
			cart_cfg.kind = cart_pkg::kind_none; // includes 00h rom only

		rom_top = (10'd2 << rom_size[3:0]) - 10'd1;
		cart_cfg.rom_mask = (rom_size <= 8'd8) ? rom_top[8:0] : 9'd127; // 52h-54h odd sizes

		if (ram_size <= 8'd2)
			cart_cfg.ram_mask = 4'd0;  // none, 2k or one 8k bank
		else if (ram_size == 8'd3)
			cart_cfg.ram_mask = 4'd3;  // 32k
		else
			cart_cfg.ram_mask = 4'd15; // 128k

		cart_cfg.cgb_game = (cgb_flag == cart_pkg::cgb_flag_dual) ||
			(cgb_flag == cart_pkg::cgb_flag_only);
	end

endmodule

`default_nettype wire

//--- design/mem_pkg.sv
/* memory geometry and the structs that carry requests and mapper state
   cpu side is the 16 bit console bus, load side is the 25 bit host stream */
`default_nettype none

package mem_pkg;

	localparam int cpu_addr_w  = 16;
	localparam int load_addr_w = 25; // byte address of the load stream
	localparam int load_data_w = 16; // one word per beat
	localparam int rom_bank_w  = 9;  // up to 512 x 16k on mbc5
	localparam int ram_bank_w  = 4;  // up to 16 x 8k

	// one cpu request, rd and wr are exclusive
	typedef struct packed {
		logic [cpu_addr_w-1:0] addr;
		logic [7:0]            wdata;
		logic                  rd;
		logic                  wr;
	} cpu_req_t;

	typedef struct packed {
		cart_pkg::mbc_kind_e   kind;
		logic [rom_bank_w-1:0] rom_mask; // mirrors banks past the rom size
		logic [ram_bank_w-1:0] ram_mask;
		logic                  cgb_game;
	} cart_cfg_t;

	typedef struct packed {
		logic [rom_bank_w-1:0] rom_bank;
		logic [ram_bank_w-1:0] ram_bank;
		logic                  mbc1_mode; // 1 = 4/32 mode
		logic                  rtc_mode;
		logic                  ram_en;
	} bank_state_t;

	typedef struct packed {
		logic [load_addr_w-1:0] addr;
		logic [load_data_w-1:0] data;
	} load_beat_t;

endpackage

`default_nettype wire

//--- design/cart_pkg.sv
/* cartridge format: header offsets, mapper kinds and write decoding
   header types outside the five kinds below are treated as plain 32 KB ROM */
`default_nettype none

package cart_pkg;

	// --------------------------------------
	// mapper kinds, decoded from header 147h
	typedef enum logic [2:0] {
		kind_none = 3'd0, // 32k linear, no registers
		kind_mbc1 = 3'd1,
		kind_mbc2 = 3'd2, // 512 x 4 bit ram on chip
		kind_mbc3 = 3'd3, // rtc not modelled
		kind_mbc5 = 3'd4
	} mbc_kind_e;

	// header words as they pass in the load stream (byte addresses, 16 bit beats)
	localparam logic [24:0] hdr_cgb_off  = 25'h142; // flag sits in the high byte
	localparam logic [24:0] hdr_type_off = 25'h146; // type in the high byte
	localparam logic [24:0] hdr_size_off = 25'h148; // rom size low, ram size high

	localparam logic [7:0] cgb_flag_dual = 8'h80; // runs on both
	localparam logic [7:0] cgb_flag_only = 8'hc0; // colour only

	// --------------------------------------
	// cpu write regions, addr[15:13] below 8000
	typedef enum logic [2:0] {
		region_ram_en   = 3'b000, // 0000-1fff
		region_rom_bank = 3'b001, // 2000-3fff
		region_ram_bank = 3'b010, // 4000-5fff
		region_mode     = 3'b011  // 6000-7fff
	} region_e;

	localparam logic [3:0] ram_en_key = 4'ha; // low nibble that opens the ram

	// data written to 4000-5fff, read differently per mapper
	typedef struct packed {
		logic [3:0] rsvd;
		logic       rtc_sel; // 08h-0ch select an rtc register
		logic       rsvd_b;
		logic [1:0] bank;
	} mbc3_bank_wr_t;

	typedef struct packed {
		logic [3:0] rsvd;
		logic [3:0] bank; // 16 ram banks
	} mbc5_bank_wr_t;

	typedef union packed {
		mbc3_bank_wr_t mbc3;
		mbc5_bank_wr_t mbc5;
	} ram_bank_wr_u;

endpackage

`default_nettype wire
